//--- hw/cmem_pkg.sv
`default_nettype none

package cmem_pkg;

  // processor side
  localparam int ADDR_WIDTH = 32;
  localparam int WORD_WIDTH = 32;
  localparam int BE_WIDTH   = 4;

  // line and dram beat
  localparam int LINE_WIDTH     = 128;
  localparam int WORDS_PER_LINE = 4;

  // address fields
  localparam int OFFSET_LSB    = 2;
  localparam int OFFSET_MSB    = 3;
  localparam int LINE_LSB      = OFFSET_MSB + 1;  // first bit above the word offset
  localparam int INDEX_WIDTH   = 6;               // 64 lines
  localparam int TAG_LSB       = LINE_LSB + INDEX_WIDTH;
  localparam int TAG_WIDTH     = 4;               // bits 13:10
  localparam int MEM_LINE_BITS = 10;              // 16 KiB backing store

  // dram model timing
  localparam int READ_LATENCY    = 15;
  localparam int CALIB_CYCLES    = 8;
  localparam int LAT_CNT_WIDTH   = 4;
  localparam int CALIB_CNT_WIDTH = 4;

  typedef enum logic [2:0] {
    wait_calib,
    idle,
    lookup,       // read result from the tag compare
    write_issue,
    read_issue,
    read_wait,
    fill          // first cycle after a line install
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- hw/dram_req_if.sv
`default_nettype none

interface dram_req_if
  import cmem_pkg::*;
();

  // request side, strobes last one cycle
  logic                  req_ren;
  logic                  req_wen;
  logic [ADDR_WIDTH-1:0] req_addr;
  logic [WORD_WIDTH-1:0] req_wdata;
  logic [BE_WIDTH-1:0]   req_be;

  // response side
  logic                  rsp_valid;  // single pulse per read
  logic [LINE_WIDTH-1:0] rsp_line;
  logic                  ready;      // calibration done
  logic                  busy;       // read in flight

  modport ctrl (
    output req_ren, req_wen, req_addr, req_wdata, req_be,
    input  rsp_valid, ready, busy
  );

  modport mem (
    input  req_ren, req_wen, req_addr, req_wdata, req_be,
    output rsp_valid, rsp_line, ready, busy
  );

  // cache installs the returned line at the request address
  modport cache (
    input rsp_line, req_addr
  );

endinterface

`default_nettype wire

//--- hw/cache_ctrl.sv
`default_nettype none

module cache_ctrl
  import cmem_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_ren,
  input  logic [BE_WIDTH-1:0]   i_be,
  input  logic [ADDR_WIDTH-1:0] i_addr,
  input  logic [WORD_WIDTH-1:0] i_wdata,
  output logic                  o_stall,
  output logic                  o_lookup,
  output logic                  o_write,
  output logic                  o_install,
  input  logic                  i_hit,
  dram_req_if.ctrl              dram
);

  ctrl_state_t state;
  ctrl_state_t state_nxt;

  logic [ADDR_WIDTH-1:0] addr_q;
  logic [WORD_WIDTH-1:0] wdata_q;
  logic [BE_WIDTH-1:0]   be_q;

  logic is_write;
  logic can_accept;
  logic accept;
  logic dram_free;

  assign is_write  = |i_be;
  assign dram_free = dram.ready && !dram.busy;

  // a read hit frees the port in the same cycle its result shows up
  assign can_accept = (state == idle) || (state == fill) ||
                      ((state == lookup) && i_hit);
  assign accept     = can_accept && (i_ren || is_write);

  assign o_stall   = !can_accept;
  assign o_lookup  = accept;
  assign o_write   = accept && is_write;
  assign o_install = (state == read_wait) && dram.rsp_valid;  // line only valid now

  assign dram.req_ren   = (state == read_issue) && dram_free;
  assign dram.req_wen   = (state == write_issue) && dram_free;
  assign dram.req_addr  = addr_q;
  assign dram.req_wdata = wdata_q;
  assign dram.req_be    = be_q;

  always_comb begin
    state_nxt = state;
    case (state)
      wait_calib: begin
        if (dram.ready) state_nxt = idle;
      end
      idle, fill, lookup: begin
        if ((state == lookup) && !i_hit) begin
          state_nxt = read_issue;  // miss, go fetch the line
        end else if (accept) begin
          state_nxt = is_write ? write_issue : lookup;
        end else begin
          state_nxt = idle;
        end
      end
      write_issue: begin
        if (dram_free) state_nxt = idle;
      end
      read_issue: begin
        if (dram_free) state_nxt = read_wait;
      end
      read_wait: begin
        if (dram.rsp_valid) state_nxt = fill;
      end
      default: state_nxt = wait_calib;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= wait_calib;
    end else begin
      state <= state_nxt;
    end
  end

  // request held for the dram side
  always_ff @(posedge i_clk) begin
    if (accept) begin
      addr_q  <= i_addr;
      wdata_q <= i_wdata;
      be_q    <= i_be;   // zero for reads
    end
  end

endmodule

`default_nettype wire

//--- hw/line_cache.sv
`default_nettype none

module line_cache
  import cmem_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_lookup,
  input  logic                  i_write,
  input  logic                  i_install,
  input  logic [ADDR_WIDTH-1:0] i_addr,
  input  logic [BE_WIDTH-1:0]   i_be,
  input  logic [WORD_WIDTH-1:0] i_wdata,
  output logic                  o_hit,
  output logic [WORD_WIDTH-1:0] o_rdata,
  dram_req_if.cache             dram
);

  logic [2**INDEX_WIDTH-1:0] valid;
  logic [TAG_WIDTH-1:0]      tags  [2**INDEX_WIDTH];
  logic [LINE_WIDTH-1:0]     lines [2**INDEX_WIDTH];

  // lookup side, from the processor address
  logic [INDEX_WIDTH-1:0]            idx;
  logic [TAG_WIDTH-1:0]              tag;
  logic [$clog2(WORDS_PER_LINE)-1:0] word;
  logic                              hit_now;
  logic [LINE_WIDTH-1:0]             cur_line;

  // install side, from the outstanding dram read
  logic [INDEX_WIDTH-1:0]            fill_idx;
  logic [TAG_WIDTH-1:0]              fill_tag;
  logic [$clog2(WORDS_PER_LINE)-1:0] fill_word;

  assign idx       = i_addr[LINE_LSB +: INDEX_WIDTH];
  assign tag       = i_addr[TAG_LSB +: TAG_WIDTH];
  assign word      = i_addr[OFFSET_MSB:OFFSET_LSB];
  assign fill_idx  = dram.req_addr[LINE_LSB +: INDEX_WIDTH];
  assign fill_tag  = dram.req_addr[TAG_LSB +: TAG_WIDTH];
  assign fill_word = dram.req_addr[OFFSET_MSB:OFFSET_LSB];

  assign hit_now  = valid[idx] && (tags[idx] == tag);
  assign cur_line = lines[idx];

  // arrays
  always_ff @(posedge i_clk) begin
    if (i_install) begin
      tags[fill_idx]  <= fill_tag;
      lines[fill_idx] <= dram.rsp_line;
    end else if (i_lookup && i_write && hit_now) begin
      for (int b = 0; b < BE_WIDTH; b++) begin
        if (i_be[b]) lines[idx][word*WORD_WIDTH + b*8 +: 8] <= i_wdata[b*8 +: 8];
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      valid   <= '0;
      o_hit   <= 1'b0;
      o_rdata <= '0;
    end else begin
      if (i_install) begin
        valid[fill_idx] <= 1'b1;
        o_rdata         <= dram.rsp_line[fill_word*WORD_WIDTH +: WORD_WIDTH];  // bypass
      end
      if (i_lookup) o_hit <= hit_now;
      if (i_lookup && !i_write) o_rdata <= cur_line[word*WORD_WIDTH +: WORD_WIDTH];
    end
  end

endmodule

`default_nettype wire

//--- hw/dram_model.sv
`default_nettype none

module dram_model
  import cmem_pkg::*;
(
  input  logic   i_clk,
  input  logic   i_rst,
  dram_req_if.mem dram
);

  logic [LINE_WIDTH-1:0] mem [2**MEM_LINE_BITS];

  logic [MEM_LINE_BITS-1:0]          line_sel;
  logic [$clog2(WORDS_PER_LINE)-1:0] lane;

  logic [CALIB_CNT_WIDTH-1:0] cal_cnt;
  logic                       ready_q;
  logic [LAT_CNT_WIDTH-1:0]   lat_cnt;
  logic                       pend_q;    // read waiting on latency
  logic                       valid_q;
  logic [MEM_LINE_BITS-1:0]   rd_line_q;
  logic [LINE_WIDTH-1:0]      line_q;

  assign line_sel = dram.req_addr[LINE_LSB +: MEM_LINE_BITS];  // upper bits ignored
  assign lane     = dram.req_addr[OFFSET_MSB:OFFSET_LSB];

  assign dram.ready     = ready_q;
  assign dram.busy      = pend_q || valid_q;
  assign dram.rsp_valid = valid_q;
  assign dram.rsp_line  = line_q;

  // word writes land in their lane
  always_ff @(posedge i_clk) begin
    if (dram.req_wen) begin
      for (int b = 0; b < BE_WIDTH; b++) begin
        if (dram.req_be[b]) begin
          mem[line_sel][lane*WORD_WIDTH + b*8 +: 8] <= dram.req_wdata[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      cal_cnt <= CALIB_CNT_WIDTH'(CALIB_CYCLES);
      ready_q <= 1'b0;
      lat_cnt <= '0;
      pend_q  <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      if (cal_cnt != '0) cal_cnt <= cal_cnt - 1'b1;
      else ready_q <= 1'b1;

      valid_q <= 1'b0;
      if (dram.req_ren) begin
        pend_q  <= 1'b1;
        lat_cnt <= LAT_CNT_WIDTH'(READ_LATENCY - 2);  // one more cycle for the data register
      end else if (pend_q) begin
        if (lat_cnt == '0) begin
          pend_q  <= 1'b0;
          valid_q <= 1'b1;
        end else begin
          lat_cnt <= lat_cnt - 1'b1;
        end
      end
    end
  end

  // read data path
  always_ff @(posedge i_clk) begin
    if (dram.req_ren) rd_line_q <= line_sel;
    if (pend_q && (lat_cnt == '0)) line_q <= mem[rd_line_q];
  end

endmodule

`default_nettype wire

//--- hw/cached_memory.sv
`default_nettype none

module cached_memory
  import cmem_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_ren,
  input  logic [BE_WIDTH-1:0]   i_be,
  input  logic [ADDR_WIDTH-1:0] i_addr,
  input  logic [WORD_WIDTH-1:0] i_wdata,
  output logic [WORD_WIDTH-1:0] o_rdata,
  output logic                  o_stall
);

  dram_req_if dram_if ();

  logic cache_lookup;
  logic cache_write;
  logic cache_install;
  logic cache_hit;

  cache_ctrl u_ctrl (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_ren     (i_ren),
    .i_be      (i_be),
    .i_addr    (i_addr),
    .i_wdata   (i_wdata),
    .o_stall   (o_stall),
    .o_lookup  (cache_lookup),
    .o_write   (cache_write),
    .o_install (cache_install),
    .i_hit     (cache_hit),
    .dram      (dram_if.ctrl)
  );

  // sees the live request in the accept cycle
  line_cache u_cache (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_lookup  (cache_lookup),
    .i_write   (cache_write),
    .i_install (cache_install),
    .i_addr    (i_addr),
    .i_be      (i_be),
    .i_wdata   (i_wdata),
    .o_hit     (cache_hit),
    .o_rdata   (o_rdata),
    .dram      (dram_if.cache)
  );

  dram_model u_dram (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .dram  (dram_if.mem)
  );

endmodule

`default_nettype wire

//--- sim/cached_memory_properties.sv
`default_nettype none

module cached_memory_properties
  import cmem_pkg::*;
(
  input logic                  i_clk,
  input logic                  i_rst,
  input logic [BE_WIDTH-1:0]   i_be,
  input logic                  i_stall,
  input logic [WORD_WIDTH-1:0] i_rdata,
  input ctrl_state_t           i_state
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int STALL_LIMIT = READ_LATENCY + 4;  // miss is lookup, issue, then latency

  int stall_run;

  always_ff @(posedge i_clk) begin
    if (i_rst || !i_stall || (i_state == wait_calib)) stall_run <= 0;
    else stall_run <= stall_run + 1;
  end

  write_stalls_one_cycle: assert property (
    @(posedge i_clk) disable iff (i_rst)
    (!i_stall && (|i_be)) |=> i_stall ##1 !i_stall
  ) else $error("accepted write did not stall for exactly one cycle");

  stall_bounded: assert property (
    @(posedge i_clk) disable iff (i_rst)
    stall_run <= STALL_LIMIT
  ) else $error("o_stall held longer than a line fetch allows");

  // read result shows in fill or on a hit in lookup
  rdata_known: assert property (
    @(posedge i_clk) disable iff (i_rst)
    ((i_state == fill) || ((i_state == lookup) && !i_stall)) |-> !$isunknown(i_rdata)
  ) else $error("o_rdata unknown after a completed read");

endmodule

bind cached_memory cached_memory_properties u_props (
  .i_clk   (i_clk),
  .i_rst   (i_rst),
  .i_be    (i_be),
  .i_stall (o_stall),
  .i_rdata (o_rdata),
  .i_state (u_ctrl.state)
);

`default_nettype wire

//--- sim/tb_cached_memory.sv
`default_nettype none

module tb_cached_memory
  import cmem_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD     = 40;
  localparam int DRIVE_DELAY    = 2;
  localparam int RESET_CYCLES   = 5;
  localparam int ACCESS_COUNT   = 300;  // directed, 64 init writes, 200 random
  localparam int TIMEOUT_CYCLES = ACCESS_COUNT * (READ_LATENCY + 8) + 200;

  logic                  i_clk = 1'b0;
  logic                  i_rst;
  logic                  i_ren;
  logic [BE_WIDTH-1:0]   i_be;
  logic [ADDR_WIDTH-1:0] i_addr;
  logic [WORD_WIDTH-1:0] i_wdata;
  logic [WORD_WIDTH-1:0] o_rdata;
  logic                  o_stall;

  logic [WORD_WIDTH-1:0] ref_mem [4096];  // 16 KiB of words
  logic [31:0]           rand_state = 32'd14;
  int                    error_count = 0;
  int                    cycle_count = 0;

  cached_memory uut (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_ren   (i_ren),
    .i_be    (i_be),
    .i_addr  (i_addr),
    .i_wdata (i_wdata),
    .o_rdata (o_rdata),
    .o_stall (o_stall)
  );

  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  // word n of 64 spread over 4 indices and 4 tags
  function automatic logic [ADDR_WIDTH-1:0] small_addr(input logic [5:0] n);
    return {20'd0, n[5:4], 4'd0, n[3:2], n[1:0], 2'b00};
  endfunction

  task automatic stop_run();
    $display("RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    stop_run();
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
      stop_run();
    end
  endtask

  always @(posedge i_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) abort_run("timeout: tests did not finish in time");
  end

  task automatic update_reference(input logic [ADDR_WIDTH-1:0] addr,
                                  input logic [BE_WIDTH-1:0] be,
                                  input logic [WORD_WIDTH-1:0] data);
    for (int b = 0; b < BE_WIDTH; b++) begin
      if (be[b]) ref_mem[addr[13:2]][b*8 +: 8] = data[b*8 +: 8];
    end
  endtask

  // starts and ends just after a rising edge
  task automatic access(input logic ren, input logic [BE_WIDTH-1:0] be,
                        input logic [ADDR_WIDTH-1:0] addr, input logic [WORD_WIDTH-1:0] wdata,
                        output logic [WORD_WIDTH-1:0] rdata, output int stalls);
    i_ren   = ren;
    i_be    = be;
    i_addr  = addr;
    i_wdata = wdata;
    @(negedge i_clk);
    while (o_stall) @(negedge i_clk);
    @(posedge i_clk);  // accepted
    #DRIVE_DELAY;
    i_ren  = 1'b0;
    i_be   = '0;
    stalls = 0;
    @(negedge i_clk);
    while (o_stall) begin
      stalls++;
      @(negedge i_clk);
    end
    rdata = o_rdata;
    @(posedge i_clk);
    #DRIVE_DELAY;
  endtask

  task automatic write_word(input logic [ADDR_WIDTH-1:0] addr, input logic [BE_WIDTH-1:0] be,
                            input logic [WORD_WIDTH-1:0] data);
    logic [WORD_WIDTH-1:0] rdata;
    int                    stalls;
    access(1'b0, be, addr, data, rdata, stalls);
    update_reference(addr, be, data);
    check_value("write_stall_cycles", stalls, 32'd1);
  endtask

  task automatic read_word(input logic [ADDR_WIDTH-1:0] addr, output int stalls);
    logic [WORD_WIDTH-1:0] rdata;
    access(1'b1, '0, addr, '0, rdata, stalls);
    check_value("o_rdata", rdata, ref_mem[addr[13:2]]);
  endtask

  task automatic expect_hit(input logic [ADDR_WIDTH-1:0] addr);
    int stalls;
    read_word(addr, stalls);
    check_value("hit_stall_cycles", stalls, 32'd0);
  endtask

  task automatic expect_miss(input logic [ADDR_WIDTH-1:0] addr);
    int stalls;
    read_word(addr, stalls);
    if (stalls == 0) abort_run("read that should miss completed without a stall");
  endtask

  task automatic calibration_stall();
    int waited;
    check_value("o_rdata", o_rdata, 32'd0);
    for (int c = 0; c < CALIB_CYCLES; c++) begin
      @(negedge i_clk);
      check_value("o_stall", 32'(o_stall), 32'd1);
    end
    waited = 0;
    while (o_stall) begin
      waited++;
      if (waited > CALIB_CYCLES) abort_run("o_stall did not fall after calibration");
      @(negedge i_clk);
    end
    @(posedge i_clk);
    #DRIVE_DELAY;
  endtask

  task automatic word_roundtrip();
    write_word(32'h0000_0100, 4'hf, 32'hA5A5_1234);
    write_word(32'h0000_0104, 4'hf, 32'h5A5A_4321);  // other word of the same line
    expect_miss(32'h0000_0100);
    expect_hit(32'h0000_0104);
    expect_hit(32'h0000_0100);
  endtask

  task automatic partial_byte_merge();
    write_word(32'h0000_0208, 4'hf, 32'h1122_3344);
    write_word(32'h0000_0208, 4'b0001, 32'h0000_00AA);
    write_word(32'h0000_0208, 4'b1100, 32'hBEEF_0000);
    expect_miss(32'h0000_0208);
    write_word(32'h0000_0208, 4'b0010, 32'h0000_CC00);  // merges into the cached line
    expect_hit(32'h0000_0208);
  endtask

  task automatic write_hit_update();
    write_word(32'h0000_0304, 4'hf, 32'h0BAD_F00D);
    expect_miss(32'h0000_0304);
    write_word(32'h0000_0304, 4'hf, 32'hC0FF_EE01);
    expect_hit(32'h0000_0304);
  endtask

  // index 4 with tags 1 and 2
  task automatic same_index_eviction();
    write_word(32'h0000_0440, 4'hf, 32'h1111_AAAA);
    write_word(32'h0000_0840, 4'hf, 32'h2222_BBBB);
    for (int k = 0; k < 2; k++) begin
      expect_miss(32'h0000_0440);
      expect_miss(32'h0000_0840);
    end
  endtask

  task automatic random_mix();
    logic [31:0]         r;
    logic [BE_WIDTH-1:0] be;
    int                  stalls;
    for (int n = 0; n < 64; n++) write_word(small_addr(6'(n)), 4'hf, next_rand());
    for (int k = 0; k < 200; k++) begin
      r = next_rand();
      if (r[31]) begin
        read_word(small_addr(r[29:24]), stalls);
      end else begin
        be = (r[23:20] == 4'h0) ? 4'hf : r[23:20];
        write_word(small_addr(r[29:24]), be, next_rand());
      end
    end
  endtask

  initial begin
    i_rst   = 1'b1;
    i_ren   = 1'b0;
    i_be    = '0;
    i_addr  = '0;
    i_wdata = '0;
    repeat (RESET_CYCLES) @(posedge i_clk);
    #DRIVE_DELAY;
    i_rst = 1'b0;
    calibration_stall();
    word_roundtrip();
    partial_byte_merge();
    write_hit_update();
    same_index_eviction();
    random_mix();
    if (error_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
hw/cmem_pkg.sv
hw/dram_req_if.sv
hw/cache_ctrl.sv
hw/line_cache.sv
hw/dram_model.sv
hw/cached_memory.sv
sim/cached_memory_properties.sv
sim/tb_cached_memory.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_cached_memory
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

# the simulation passes only if the pass line shows up in its output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)
